// File: Bender.yml
package:
  name: wb_stage

sources:
  - files:
      - hw/wb_types_pkg.sv
      - hw/wb_ctrl_pkg.sv
      - hw/wb_input_latch.sv
      - hw/wb_route.sv
      - hw/wb_reg_file.sv
      - hw/wb_mem_queue.sv
      - hw/wb_top.sv

  - target: test
    files:
      - verif/tb_wb_top.sv

// File: hw/wb_ctrl_pkg.sv
`default_nettype none

package wb_ctrl_pkg;

    typedef struct packed {
        logic       halt;
        logic       far_xfer;  // far jmp/call/ret
        logic [3:0] size_ovr;  // one-hot memory size override
    } wb_op_t;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        correct;
        logic [31:0] fip;
        logic [31:0] fip_p1;   // next fetch line
    } wb_branch_t;

    typedef struct packed {
        logic       val;
        logic [2:0] kind;
    } wb_exc_t;

    // exception after interrupt merge
    typedef struct packed {
        logic       val;
        logic       intr;
        logic [2:0] kind;
    } wb_final_exc_t;

endpackage

`default_nettype wire

// File: hw/wb_input_latch.sv
`timescale 1ns/1ps
`default_nettype none

module wb_input_latch (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 stall,
    input  logic                                                 in_valid,
    input  wb_types_pkg::wb_slot_t [wb_types_pkg::NUM_SLOTS-1:0] in_slots,
    input  wb_types_pkg::wb_size_t                               in_size,
    input  logic [31:0]                                          in_eip,
    input  wb_ctrl_pkg::wb_op_t                                  in_op,
    input  wb_ctrl_pkg::wb_branch_t                              in_br,
    input  wb_ctrl_pkg::wb_exc_t                                 in_exc,
    output logic                                                 q_valid,
    output wb_types_pkg::wb_slot_t [wb_types_pkg::NUM_SLOTS-1:0] q_slots,
    output wb_types_pkg::wb_size_t                               q_size,
    output logic [31:0]                                          q_eip,
    output wb_ctrl_pkg::wb_op_t                                  q_op,
    output wb_ctrl_pkg::wb_branch_t                              q_br,
    output wb_ctrl_pkg::wb_exc_t                                 q_exc
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (!stall) begin
            q_valid <= in_valid;
        end
    end

    // payload just follows the valid bit
    always_ff @(posedge clk) begin
        if (!stall) begin
            q_slots <= in_slots;
            q_size  <= in_size;
            q_eip   <= in_eip;
            q_op    <= in_op;
            q_br    <= in_br;
            q_exc   <= in_exc;
        end
    end

    // a held bundle must not retire or vanish while the queue backs up
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> q_valid ##1 q_valid);

endmodule

`default_nettype wire

// File: hw/wb_mem_queue.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  wb_types_pkg::wb_mem_entry_t entry,
    input  logic                        mem_ack,
    output logic                        full,
    output logic                        mem_req,
    output wb_types_pkg::wb_mem_entry_t mem_head
);

    import wb_types_pkg::*;

    wb_mem_entry_t      mem [WBAQ_DEPTH];
    logic [WBAQ_AW-1:0] wr_ptr;
    logic [WBAQ_AW-1:0] rd_ptr;
    logic [WBAQ_AW:0]   count;
    logic               pop;
    logic               do_push;

    assign full     = (count == (WBAQ_AW + 1)'(WBAQ_DEPTH));
    assign mem_req  = (count != '0);
    assign mem_head = mem[rd_ptr];

    assign pop     = mem_ack && mem_req;
    assign do_push = push && (!full || pop);  // full is seen before the pop

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == WBAQ_AW'(WBAQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == WBAQ_AW'(WBAQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry;
        end
    end

    // upstream stall must keep pushes off a full queue
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push && full |-> mem_ack);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack |-> mem_req);

endmodule

`default_nettype wire

// File: hw/wb_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module wb_reg_file (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  wb_types_pkg::wb_slot_t [wb_types_pkg::NUM_SLOTS-1:0] slots,
    input  wb_types_pkg::wb_size_t                               size,
    input  logic [wb_types_pkg::NUM_SLOTS-1:0]                   reg_ld,
    input  logic [wb_types_pkg::NUM_SLOTS-1:0]                   seg_ld,
    input  logic                                                 cs_ld,
    input  logic [15:0]                                          cs_value,
    input  logic [2:0]                                           gpr_rd_addr,
    output logic [31:0]                                          gpr_rd_data,
    input  logic [2:0]                                           seg_rd_addr,
    output logic [15:0]                                          seg_rd_data
);

    import wb_types_pkg::*;

    localparam logic [2:0] CS_IDX = 3'd1;

    logic [7:0][31:0] gpr;
    logic [7:0][31:0] gpr_nxt;
    logic [7:0][15:0] seg;
    logic [7:0][15:0] seg_nxt;
    logic [2:0]       idx;

    // slots applied in order, later slot wins and merges over earlier
    always_comb begin
        gpr_nxt = gpr;
        seg_nxt = seg;
        idx     = 3'd0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            idx = slots[i].dest[2:0];
            if (reg_ld[i]) begin
                case (size)
                    SZ_BYTE: gpr_nxt[idx][7:0]  = slots[i].value.data[7:0];
                    SZ_WORD: gpr_nxt[idx][15:0] = slots[i].value.data[15:0];
                    default: gpr_nxt[idx]       = slots[i].value.data[31:0];
                endcase
            end
            if (seg_ld[i]) begin
                seg_nxt[idx] = slots[i].value.data[15:0];
            end
        end
        if (cs_ld) begin
            seg_nxt[CS_IDX] = cs_value;  // far transfer overrides any slot write
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpr <= '0;
            seg <= '0;
        end else begin
            gpr <= gpr_nxt;
            seg <= seg_nxt;
        end
    end

    assign gpr_rd_data = gpr[gpr_rd_addr];
    assign seg_rd_data = seg[seg_rd_addr];

endmodule

`default_nettype wire

// File: hw/wb_route.sv
`timescale 1ns/1ps
`default_nettype none

module wb_route (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 valid,
    input  wb_types_pkg::wb_slot_t [wb_types_pkg::NUM_SLOTS-1:0] slots,
    input  wb_types_pkg::wb_size_t                               size,
    input  logic [31:0]                                          eip,
    input  wb_ctrl_pkg::wb_op_t                                  op,
    input  wb_ctrl_pkg::wb_branch_t                              br,
    input  wb_ctrl_pkg::wb_exc_t                                 exc,
    input  logic                                                 interrupt,
    input  logic                                                 wbaq_full,
    output logic [wb_types_pkg::NUM_SLOTS-1:0]                   reg_ld,
    output logic [wb_types_pkg::NUM_SLOTS-1:0]                   seg_ld,
    output logic                                                 cs_ld,
    output logic [15:0]                                          cs_value,
    output logic                                                 mem_push,
    output wb_types_pkg::wb_mem_entry_t                          mem_entry,
    output logic                                                 stall,
    output logic [31:0]                                          new_eip,
    output logic [31:0]                                          new_fip_e,
    output logic [31:0]                                          new_fip_o,
    output logic                                                 resteer,
    output wb_ctrl_pkg::wb_final_exc_t                           final_exc,
    output logic                                                 halted
);

    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    logic [NUM_SLOTS-1:0] mem_sel;  // memory slots, before stall
    logic                 fire;     // bundle retires this cycle
    logic [31:0]          line_a;
    logic [31:0]          line_b;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            mem_sel[i] = valid && slots[i].wb && slots[i].is_mem;
        end
    end

    assign stall = (|mem_sel) && wbaq_full;
    assign fire  = valid && !stall;

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            reg_ld[i] = fire && slots[i].wb && slots[i].is_reg;
            seg_ld[i] = fire && slots[i].wb && slots[i].is_seg;
        end
    end

    assign cs_ld    = fire && op.far_xfer;
    assign cs_value = slots[0].value.far.sel;
    assign mem_push = fire && (|mem_sel);

    // walk down so the lowest memory slot is the one kept
    always_comb begin
        mem_entry.addr = slots[0].dest;
        mem_entry.data = slots[0].value.data;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_sel[i]) begin
                mem_entry.addr = slots[i].dest;
                mem_entry.data = slots[i].value.data;
            end
        end
        if (op.size_ovr[0])      mem_entry.size = SZ_BYTE;
        else if (op.size_ovr[1]) mem_entry.size = SZ_WORD;
        else if (op.size_ovr[2]) mem_entry.size = SZ_DWORD;
        else if (op.size_ovr[3]) mem_entry.size = SZ_QWORD;
        else if (op.far_xfer)    mem_entry.size = SZ_QWORD;  // far ptr push
        else                     mem_entry.size = size;
    end

    always_comb begin
        if (!br.taken)        new_eip = eip;
        else if (op.far_xfer) new_eip = slots[0].value.far.offset;
        else                  new_eip = br.fip;
    end

    assign line_a = {br.fip[31:4], 4'd0};
    assign line_b = {br.fip_p1[31:4], 4'd0};

    // even bank gets whichever line has bit 4 clear
    assign new_fip_e = br.fip[4] ? line_b : line_a;
    assign new_fip_o = br.fip[4] ? line_a : line_b;

    assign resteer = fire && br.valid && !br.correct;

    assign final_exc.val  = exc.val || interrupt;
    assign final_exc.intr = interrupt;
    assign final_exc.kind = exc.kind;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (fire && op.halt) begin
            halted <= 1'b1;  // sticky until reset
        end
    end

    // the queue takes one entry per bundle
    a_one_mem_slot: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> $onehot0(mem_sel));

endmodule

`default_nettype wire

// File: hw/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 in_valid,
    input  wb_types_pkg::wb_slot_t [wb_types_pkg::NUM_SLOTS-1:0] in_slots,
    input  wb_types_pkg::wb_size_t                               in_size,
    input  logic [31:0]                                          in_eip,
    input  wb_ctrl_pkg::wb_op_t                                  in_op,
    input  wb_ctrl_pkg::wb_branch_t                              in_br,
    input  wb_ctrl_pkg::wb_exc_t                                 in_exc,
    input  logic                                                 interrupt,
    input  logic                                                 mem_ack,
    input  logic [2:0]                                           gpr_rd_addr,
    input  logic [2:0]                                           seg_rd_addr,
    output logic                                                 stall,
    output logic [31:0]                                          new_eip,
    output logic [31:0]                                          new_fip_e,
    output logic [31:0]                                          new_fip_o,
    output logic                                                 resteer,
    output wb_ctrl_pkg::wb_final_exc_t                           final_exc,
    output logic                                                 halted,
    output logic [31:0]                                          gpr_rd_data,
    output logic [15:0]                                          seg_rd_data,
    output logic                                                 mem_req,
    output wb_types_pkg::wb_mem_entry_t                          mem_head
);

    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    // latched bundle
    logic                           q_valid;
    wb_slot_t [NUM_SLOTS-1:0]       q_slots;
    wb_size_t                       q_size;
    logic [31:0]                    q_eip;
    wb_op_t                         q_op;
    wb_branch_t                     q_br;
    wb_exc_t                        q_exc;

    logic [NUM_SLOTS-1:0]           reg_ld;
    logic [NUM_SLOTS-1:0]           seg_ld;
    logic                           cs_ld;
    logic [15:0]                    cs_value;
    logic                           mem_push;
    wb_mem_entry_t                  mem_entry;
    logic                           wbaq_full;

    wb_input_latch u_latch (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .in_valid (in_valid),
        .in_slots (in_slots),
        .in_size  (in_size),
        .in_eip   (in_eip),
        .in_op    (in_op),
        .in_br    (in_br),
        .in_exc   (in_exc),
        .q_valid  (q_valid),
        .q_slots  (q_slots),
        .q_size   (q_size),
        .q_eip    (q_eip),
        .q_op     (q_op),
        .q_br     (q_br),
        .q_exc    (q_exc)
    );

    wb_route u_route (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (q_valid),
        .slots     (q_slots),
        .size      (q_size),
        .eip       (q_eip),
        .op        (q_op),
        .br        (q_br),
        .exc       (q_exc),
        .interrupt (interrupt),
        .wbaq_full (wbaq_full),
        .reg_ld    (reg_ld),
        .seg_ld    (seg_ld),
        .cs_ld     (cs_ld),
        .cs_value  (cs_value),
        .mem_push  (mem_push),
        .mem_entry (mem_entry),
        .stall     (stall),
        .new_eip   (new_eip),
        .new_fip_e (new_fip_e),
        .new_fip_o (new_fip_o),
        .resteer   (resteer),
        .final_exc (final_exc),
        .halted    (halted)
    );

    wb_reg_file u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .slots       (q_slots),
        .size        (q_size),
        .reg_ld      (reg_ld),
        .seg_ld      (seg_ld),
        .cs_ld       (cs_ld),
        .cs_value    (cs_value),
        .gpr_rd_addr (gpr_rd_addr),
        .gpr_rd_data (gpr_rd_data),
        .seg_rd_addr (seg_rd_addr),
        .seg_rd_data (seg_rd_data)
    );

    wb_mem_queue u_wbaq (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mem_push),
        .entry    (mem_entry),
        .mem_ack  (mem_ack),
        .full     (wbaq_full),
        .mem_req  (mem_req),
        .mem_head (mem_head)
    );

endmodule

`default_nettype wire

// File: hw/wb_types_pkg.sv
`default_nettype none

package wb_types_pkg;

    localparam int NUM_SLOTS  = 4;
    localparam int WBAQ_DEPTH = 4;
    localparam int WBAQ_AW    = $clog2(WBAQ_DEPTH);  // queue pointer width

    typedef logic [1:0] wb_size_t;

    localparam wb_size_t SZ_BYTE  = 2'b00;
    localparam wb_size_t SZ_WORD  = 2'b01;
    localparam wb_size_t SZ_DWORD = 2'b10;
    localparam wb_size_t SZ_QWORD = 2'b11;

    // far pointer as left in slot 0 by far jmp/call/ret
    typedef struct packed {
        logic [15:0] pad;
        logic [15:0] sel;
        logic [31:0] offset;
    } wb_far_t;

    typedef union packed {
        logic [63:0] data;
        wb_far_t     far;
    } wb_value_u;

    typedef struct packed {
        wb_value_u   value;
        logic [31:0] dest;     // reg index in [2:0], else mem address
        logic        is_reg;
        logic        is_seg;
        logic        is_mem;
        logic        wb;
    } wb_slot_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        wb_size_t    size;
    } wb_mem_entry_t;

endpackage

`default_nettype wire

// File: sources.f
hw/wb_types_pkg.sv
hw/wb_ctrl_pkg.sv
hw/wb_input_latch.sv
hw/wb_route.sv
hw/wb_reg_file.sv
hw/wb_mem_queue.sv
hw/wb_top.sv
verif/tb_wb_top.sv

// File: verif/tb_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_top;

    import wb_types_pkg::*;
    import wb_ctrl_pkg::*;

    localparam int NUM_BUNDLES = 600;
    localparam int CLK_HALF    = 20;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    wb_slot_t [NUM_SLOTS-1:0] in_slots;
    wb_size_t                 in_size;
    logic [31:0]              in_eip;
    wb_op_t                   in_op;
    wb_branch_t               in_br;
    wb_exc_t                  in_exc;
    logic                     interrupt;
    logic                     mem_ack;
    logic [2:0]               gpr_rd_addr;
    logic [2:0]               seg_rd_addr;
    logic                     stall;
    logic [31:0]              new_eip;
    logic [31:0]              new_fip_e;
    logic [31:0]              new_fip_o;
    logic                     resteer;
    wb_final_exc_t            final_exc;
    logic                     halted;
    logic [31:0]              gpr_rd_data;
    logic [15:0]              seg_rd_data;
    logic                     mem_req;
    wb_mem_entry_t            mem_head;

    // reference model state
    logic [31:0]              m_gpr [8];
    logic [15:0]              m_seg [8];
    wb_mem_entry_t            m_q [$];
    logic                     m_halted;
    logic                     mq_valid;     // model copy of the latched bundle
    wb_slot_t [NUM_SLOTS-1:0] mq_slots;
    wb_size_t                 mq_size;
    logic [31:0]              mq_eip;
    wb_op_t                   mq_op;
    wb_branch_t               mq_br;
    wb_exc_t                  mq_exc;

    logic [31:0]              rng_state = 32'hf0bcc892;
    int                       accepted;
    int                       drain;
    int                       ack_gap;      // cycles left with ack held low
    logic                     nx_ack;
    logic                     exp_stall;
    logic                     reset_done;

    wb_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // 40 cycles per bundle is far more than back-pressure can cost
    initial begin
        #(NUM_BUNDLES * 40 * 40 + 20000);
        $display("watchdog expired before all bundles were retired");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};  // low bits of an lcg are weak
    endfunction

    task automatic compare_values(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
        if (exp !== act) begin
            $display("error: %s expected %0h actual %0h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic logic [31:0] expected_eip();
        if (!mq_br.taken) return mq_eip;
        if (mq_op.far_xfer) return mq_slots[0].value.far.offset;
        return mq_br.fip;
    endfunction

    function automatic wb_size_t expected_mem_size();
        case (mq_op.size_ovr)
            4'b0001: return 2'b00;
            4'b0010: return 2'b01;
            4'b0100: return 2'b10;
            4'b1000: return 2'b11;
            default: return mq_op.far_xfer ? 2'b11 : mq_size;
        endcase
    endfunction

    task automatic clear_model();
        for (int i = 0; i < 8; i++) begin
            m_gpr[i] = '0;
            m_seg[i] = '0;
        end
        m_q.delete();
        m_halted = 1'b0;
        mq_valid = 1'b0;
        nx_ack   = 1'b0;
        ack_gap  = 0;
    endtask

    // one new bundle, at most one store slot
    task automatic drive_bundle(input logic idle);
        wb_slot_t [NUM_SLOTS-1:0] s;
        wb_op_t                   op;
        wb_branch_t               br;
        wb_exc_t                  exc;
        logic [31:0]              r;
        int                       mem_slot;
        mem_slot = int'(next_rand() % 32'd8);  // 4..7 means no store
        for (int i = 0; i < NUM_SLOTS; i++) begin
            r = next_rand();
            s[i].value.data = {next_rand(), next_rand()};
            s[i].dest       = next_rand();
            s[i].wb         = (r[2:0] != 3'd0);
            s[i].is_reg     = r[3];
            s[i].is_seg     = !r[3] && r[4];
            s[i].is_mem     = (i == mem_slot);
            if (s[i].is_mem) begin
                s[i].is_reg = 1'b0;
                s[i].is_seg = 1'b0;
            end
        end
        r = next_rand();
        op.halt     = (r[6:0] == 7'd0);
        op.far_xfer = (r[10:8] == 3'd0);
        op.size_ovr = (r[12:11] == 2'd0) ? (4'b0001 << r[14:13]) : 4'b0000;
        exc.val     = (r[17:15] == 3'd0);
        exc.kind    = r[20:18];
        r = next_rand();
        br.valid    = r[0];
        br.taken    = r[1];
        br.correct  = (r[3:2] != 2'd0);
        br.fip      = next_rand();
        br.fip_p1   = {br.fip[31:4] + 28'd1, r[7:4]};  // following fetch line
        in_valid <= !idle && (r[10:8] != 3'd0);
        in_slots <= s;
        in_size  <= r[12:11];
        in_eip   <= next_rand();
        in_op    <= op;
        in_br    <= br;
        in_exc   <= exc;
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        r = next_rand();
        mem_ack     <= nx_ack;
        interrupt   <= (r[3:0] == 4'd0);
        gpr_rd_addr <= gpr_rd_addr + 3'd1;  // sweeps all registers
        seg_rd_addr <= r[6:4];
        if (!exp_stall) begin
            drive_bundle(accepted >= NUM_BUNDLES);
        end
    endtask

    // compare the cycle's outputs, then step the model to the next edge
    task automatic check_cycle();
        logic          fire;
        logic          has_mem;
        logic          found;
        logic [2:0]    idx;
        logic [31:0]   keep;
        logic [31:0]   line_a;
        logic [31:0]   line_b;
        logic [31:0]   r;
        wb_final_exc_t fexc;
        wb_mem_entry_t ent;
        has_mem = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            has_mem = has_mem || (mq_slots[i].wb && mq_slots[i].is_mem);
        end
        exp_stall = mq_valid && has_mem && (m_q.size() == WBAQ_DEPTH);
        fire      = mq_valid && !exp_stall;
        compare_values("stall", exp_stall, stall);
        compare_values("resteer", fire && mq_br.valid && !mq_br.correct, resteer);
        compare_values("halted", m_halted, halted);
        compare_values("mem_req", m_q.size() != 0, mem_req);
        compare_values($sformatf("gpr[%0d]", gpr_rd_addr), m_gpr[gpr_rd_addr], gpr_rd_data);
        compare_values($sformatf("seg[%0d]", seg_rd_addr), m_seg[seg_rd_addr], seg_rd_data);
        if (mq_valid) begin
            line_a    = {mq_br.fip[31:4], 4'h0};
            line_b    = {mq_br.fip_p1[31:4], 4'h0};
            fexc.val  = mq_exc.val || interrupt;
            fexc.intr = interrupt;
            fexc.kind = mq_exc.kind;
            compare_values("new_eip", expected_eip(), new_eip);
            compare_values("new_fip_e", line_a[4] ? line_b : line_a, new_fip_e);
            compare_values("new_fip_o", line_a[4] ? line_a : line_b, new_fip_o);
            compare_values("final_exc", fexc, final_exc);
        end
        if (mem_ack && m_q.size() != 0) begin
            compare_values("mem_head", m_q[0], mem_head);
            void'(m_q.pop_front());
        end
        if (fire) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                idx = mq_slots[i].dest[2:0];
                if (mq_slots[i].wb && mq_slots[i].is_reg) begin
                    keep = (mq_size == 2'b00) ? 32'hffff_ff00 :
                           (mq_size == 2'b01) ? 32'hffff_0000 : 32'h0;
                    m_gpr[idx] = (m_gpr[idx] & keep) | (mq_slots[i].value.data[31:0] & ~keep);
                end
                if (mq_slots[i].wb && mq_slots[i].is_seg) begin
                    m_seg[idx] = mq_slots[i].value.data[15:0];
                end
            end
            if (mq_op.far_xfer) begin
                m_seg[1] = mq_slots[0].value.far.sel;  // cs
            end
            found = 1'b0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (!found && mq_slots[i].wb && mq_slots[i].is_mem) begin
                    found    = 1'b1;
                    ent.addr = mq_slots[i].dest;
                    ent.data = mq_slots[i].value.data;
                    ent.size = expected_mem_size();
                    m_q.push_back(ent);
                end
            end
            if (mq_op.halt) begin
                m_halted = 1'b1;
            end
        end
        if (!exp_stall) begin
            mq_valid = in_valid;
            mq_slots = in_slots;
            mq_size  = in_size;
            mq_eip   = in_eip;
            mq_op    = in_op;
            mq_br    = in_br;
            mq_exc   = in_exc;
            if (in_valid) accepted++;
        end
        // ack in random bursts so the queue backs up now and then
        if (ack_gap > 0) begin
            ack_gap--;
            nx_ack = 1'b0;
        end else begin
            r = next_rand();
            if (r[3:0] == 4'd0) ack_gap = int'(r[7:5]) + 6;
            nx_ack = (r[9:8] != 2'd0) && (m_q.size() != 0);
        end
    endtask

    task automatic mid_run_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        mem_ack   <= 1'b0;
        interrupt <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        clear_model();  // halt, registers and queue all back to zero
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_slots    = '0;
        in_size     = '0;
        in_eip      = '0;
        in_op       = '0;
        in_br       = '0;
        in_exc      = '0;
        interrupt   = 1'b0;
        mem_ack     = 1'b0;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
        accepted    = 0;
        drain       = 0;
        reset_done  = 1'b0;
        exp_stall   = 1'b0;
        clear_model();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // run on until the last bundle has retired and every store popped
        while (drain < 8 || mq_valid || m_q.size() != 0) begin
            @(negedge clk);
            check_cycle();
            if (accepted >= NUM_BUNDLES) drain++;
            if (!reset_done && accepted >= NUM_BUNDLES / 2) begin
                reset_done = 1'b1;
                mid_run_reset();
            end else begin
                @(posedge clk);
                drive_cycle();
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
